// File: rx_pkt_pkg.sv
// beat structs and header word layout, imported by the writer, the sender and the testbench
`default_nettype none

package rx_pkt_pkg;

    //////////////////////////////
    // widths

    localparam int DATA_W = 64;          // one ring word = one stream beat
    localparam int STRB_W = DATA_W / 8;  // byte lanes per beat
    localparam int LEN_W  = 16;          // packet length in bytes

    // length field inside the header word
    localparam int HDR_LEN_LSB = 32;
    localparam int HDR_LEN_MSB = 47;  // LEN_W bits wide

    //////////////////////////////
    // stream beats

    // mac side, nbytes only valid with last
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              last;    // final beat of the packet
        logic [3:0]        nbytes;  // 1..8 valid bytes on the last beat
    } rx_beat_t;

    // backend side
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;  // all ones except on the last beat
        logic [LEN_W-1:0]  user;  // packet length, same on every beat
        logic              last;
    } bkd_beat_t;

endpackage

`default_nettype wire

// File: ibuf_pkg.sv
// FSM encodings for the ring writer and the backend sender, and the default ring size
`default_nettype none

package ibuf_pkg;

    localparam int IBUF_BW_DEF = 9;  // ring holds 2**BW words

    // writer, one pass per packet
    typedef enum logic [1:0] {
        HDR_RESERVE,  // skip one slot for the length header
        DATA,         // payload beats go in
        HDR_WRITE,    // length into the reserved slot
        COMMIT        // publish producer pointer
    } wr_state_t;

    // sender
    typedef enum logic [3:0] {
        IDLE,       // out of reset
        WAIT_HDR,   // wait for a committed packet
        DECODE,     // header on the read port
        FIRST,      // first data word on the read port
        STREAM,     // beat out, next word prefetched
        HOLD,       // back-pressure, prefetched word parked in skid
        LAST,       // last beat out
        DRAIN,      // ring ran dry mid packet, flush current beat
        WAIT_DATA,  // valid low until producer moves
        RESUME      // refetched word on the read port
    } snd_state_t;

endpackage

`default_nettype wire

// File: ibuf_ram.sv
// ring storage of the input buffer, one write port and one read port with a registered output
`timescale 1ns/1ps
`default_nettype none

module ibuf_ram
    import ibuf_pkg::*;
    import rx_pkt_pkg::*;
#(
    parameter int BW = IBUF_BW_DEF  // address width, 2**BW words
) (
    input  wire              clk,

    // write port, from the writer
    input  wire              wr_en_i,
    input  wire [BW-1:0]     wr_addr_i,
    input  wire [DATA_W-1:0] wr_data_i,

    // read port, data one cycle after the address
    input  wire [BW-1:0]     rd_addr_i,
    output logic [DATA_W-1:0] rd_data_o
);

    logic [DATA_W-1:0] mem [2**BW];  // no reset, contents only valid once committed

    //////////////////////////////
    // write side
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read side, old data on a same-address collision
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];  // fixed 1 cycle latency, sender prefetch relies on it
    end

endmodule

`default_nettype wire

// File: mac2ibuf.sv
// ring writer, takes mac beats, writes them behind a header slot and publishes the producer pointer
`timescale 1ns/1ps
`default_nettype none

module mac2ibuf
    import ibuf_pkg::*;
    import rx_pkt_pkg::*;
#(
    parameter int BW = IBUF_BW_DEF
) (
    input  wire              clk,
    input  wire              rst,

    // mac side stream
    input  wire rx_beat_t    in_i,
    input  wire              in_valid_i,
    output logic             in_ready_o,

    // ring write port
    output logic             wr_en_o,
    output logic [BW-1:0]    wr_addr_o,
    output logic [DATA_W-1:0] wr_data_o,

    // pointer exchange with the sender
    output logic [BW:0]      committed_prod_o,
    input  wire [BW:0]       committed_cons_i
);

    localparam int RING_WORDS = 2**BW;

    wr_state_t         state;
    logic [BW:0]       wr_ptr;    // next free word, one bit wider than the address
    logic [BW:0]       hdr_ptr;   // slot kept for the header of the current packet
    logic [LEN_W-1:0]  byte_cnt;  // bytes of the packet so far
    logic [BW:0]       used;      // words not yet freed by the sender
    logic [BW:0]       free;
    logic [BW:0]       wr_tgt;    // full pointer of the word written this cycle
    logic [DATA_W-1:0] hdr_word;
    logic              beat_ok;   // beat transfer

    //////////////////////////////
    // space and handshake
    assign used       = wr_ptr - committed_cons_i;
    assign free       = (BW+1)'(RING_WORDS) - used;
    assign in_ready_o = (state == DATA) && (free >= (BW+1)'(2));  // keep 1 word of margin
    assign beat_ok    = in_valid_i && in_ready_o;

    // header, only the length field is populated
    always_comb begin
        hdr_word = '0;
        hdr_word[HDR_LEN_MSB:HDR_LEN_LSB] = byte_cnt;
    end

    // write port, data beats straight through, header into the kept slot
    assign wr_en_o   = beat_ok || (state == HDR_WRITE);
    assign wr_tgt    = (state == HDR_WRITE) ? hdr_ptr : wr_ptr;
    assign wr_addr_o = wr_tgt[BW-1:0];
    assign wr_data_o = (state == HDR_WRITE) ? hdr_word : in_i.data;

    //////////////////////////////
    // writer FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= HDR_RESERVE;
            wr_ptr           <= '0;
            committed_prod_o <= '0;
        end else begin
            case (state)
                HDR_RESERVE: begin
                    hdr_ptr  <= wr_ptr;
                    wr_ptr   <= wr_ptr + 1'b1;  // header slot skipped
                    byte_cnt <= '0;
                    state    <= DATA;
                end
                DATA: begin
                    if (beat_ok) begin
                        wr_ptr <= wr_ptr + 1'b1;
                        if (in_i.last) begin
                            byte_cnt <= byte_cnt + LEN_W'(in_i.nbytes);
                            state    <= HDR_WRITE;
                        end else begin
                            byte_cnt <= byte_cnt + LEN_W'(8);  // full beat
                        end
                    end
                end
                HDR_WRITE: begin
                    state <= COMMIT;  // header write happens on the port this cycle
                end
                COMMIT: begin
                    committed_prod_o <= wr_ptr;  // whole packet visible at once
                    state            <= HDR_RESERVE;
                end
                default: state <= HDR_RESERVE;
            endcase
        end
    end

    //////////////////////////////
    // checks

    // any write target must sit in space the sender has already given back
    assert property (@(posedge clk) disable iff (rst)
        wr_en_o |-> ((BW+1)'(wr_tgt - committed_cons_i) < (BW+1)'(RING_WORDS)));

    // byte count on the last beat from the mac side
    assert property (@(posedge clk) disable iff (rst)
        (beat_ok && in_i.last) |-> (in_i.nbytes inside {[4'd1:4'd8]}));

endmodule

`default_nettype wire

// File: ibuf2bkd.sv
// backend sender, reads committed packets out of the ring and streams them with strobes and length
`timescale 1ns/1ps
`default_nettype none

module ibuf2bkd
    import ibuf_pkg::*;
    import rx_pkt_pkg::*;
#(
    parameter int BW = IBUF_BW_DEF
) (
    input  wire              clk,
    input  wire              rst,

    // ring read port
    output logic [BW-1:0]    rd_addr_o,
    input  wire [DATA_W-1:0] rd_data_i,

    // pointer exchange with the writer
    input  wire [BW:0]       committed_prod_i,
    output logic [BW:0]      committed_cons_o,

    // backend stream
    output bkd_beat_t        bkd_o,
    output logic             bkd_valid_o,
    input  wire              bkd_ready_i
);

    localparam int QW_W = LEN_W - 2;  // quad-word count of a max length packet

    snd_state_t        state;
    logic [BW:0]       rd_ptr;     // next word to read, doubles as consumer pointer
    logic [BW:0]       avail;      // committed words not read yet
    logic [LEN_W-1:0]  len;
    logic [LEN_W-1:0]  hdr_len;
    logic [QW_W-1:0]   hdr_qw;
    logic [QW_W-1:0]   iss_left;   // data words still to fetch for this packet
    logic [STRB_W-1:0] last_strb;
    logic [DATA_W-1:0] skid;       // prefetched word parked under back-pressure
    logic [DATA_W-1:0] load_word;
    logic              load;       // a new beat goes onto the output this cycle
    bkd_beat_t         beat_q;
    logic              valid_q;

    assign avail            = committed_prod_i - rd_ptr;
    assign rd_addr_o        = rd_ptr[BW-1:0];
    assign committed_cons_o = rd_ptr;
    assign bkd_o            = beat_q;
    assign bkd_valid_o      = valid_q;

    //////////////////////////////
    // header decode, valid while in DECODE
    assign hdr_len = rd_data_i[HDR_LEN_MSB:HDR_LEN_LSB];
    assign hdr_qw  = QW_W'(hdr_len[LEN_W-1:3]) + QW_W'(hdr_len[2:0] != 3'd0);  // round up

    // beat load, from the read port or from the skid
    assign load_word = (state == HOLD) ? skid : rd_data_i;
    assign load      = (state == FIRST) || (state == RESUME)
                    || (((state == STREAM) || (state == HOLD)) && bkd_ready_i);

    //////////////////////////////
    // sender FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            rd_ptr  <= '0;
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q      <= 1'b1;
            beat_q.data  <= load_word;
            beat_q.user  <= len;
            if (iss_left == '0) begin  // nothing left to fetch, this is the last word
                beat_q.strb <= last_strb;
                beat_q.last <= 1'b1;
                state       <= LAST;
            end else begin
                beat_q.strb <= '1;
                beat_q.last <= 1'b0;
                if (avail != '0) begin  // prefetch next word
                    rd_ptr   <= rd_ptr + 1'b1;
                    iss_left <= iss_left - 1'b1;
                    state    <= STREAM;
                end else begin
                    state <= DRAIN;  // producer behind
                end
            end
        end else begin
            case (state)
                IDLE: state <= WAIT_HDR;
                WAIT_HDR: begin
                    if (avail >= (BW+1)'(2)) begin  // header plus data committed
                        rd_ptr <= rd_ptr + 1'b1;
                        state  <= DECODE;
                    end
                end
                DECODE: begin
                    len       <= hdr_len;
                    last_strb <= (hdr_len[2:0] == 3'd0) ? '1 : ~(8'hff << hdr_len[2:0]);
                    iss_left  <= hdr_qw - 1'b1;  // first word fetched now
                    rd_ptr    <= rd_ptr + 1'b1;
                    state     <= FIRST;
                end
                STREAM: begin  // ready low, read port moves on next cycle
                    skid  <= rd_data_i;
                    state <= HOLD;
                end
                LAST: begin
                    if (bkd_ready_i) begin
                        valid_q     <= 1'b0;
                        beat_q.last <= 1'b0;
                        if (avail >= (BW+1)'(2)) begin  // back to back, header fetch now
                            rd_ptr <= rd_ptr + 1'b1;
                            state  <= DECODE;
                        end else begin
                            state <= WAIT_HDR;
                        end
                    end
                end
                DRAIN: begin
                    if (bkd_ready_i) begin
                        valid_q <= 1'b0;
                        state   <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (avail != '0) begin
                        rd_ptr   <= rd_ptr + 1'b1;
                        iss_left <= iss_left - 1'b1;
                        state    <= RESUME;
                    end
                end
                HOLD: begin
                    // parked until ready, load takes the skid word
                end
                default: state <= IDLE;
            endcase
        end
    end

    //////////////////////////////
    // checks

    // beat held under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        (valid_q && !bkd_ready_i) |=> (valid_q && $stable(beat_q)));

    // consumer never overtakes producer, gap stays within the ring
    assert property (@(posedge clk) disable iff (rst)
        avail <= (BW+1)'(2**BW));

endmodule

`default_nettype wire

// File: rx_ibuf_top.sv
// receive path top level, ring storage between the mac side writer and the backend sender
`timescale 1ns/1ps
`default_nettype none

module rx_ibuf_top
    import ibuf_pkg::*;
    import rx_pkt_pkg::*;
#(
    parameter int BW = IBUF_BW_DEF  // ring address width, passed to every block
) (
    input  wire           clk,
    input  wire           rst,

    // mac side
    input  wire rx_beat_t in_i,
    input  wire           in_valid_i,
    output logic          in_ready_o,

    // backend side
    output bkd_beat_t     bkd_o,
    output logic          bkd_valid_o,
    input  wire           bkd_ready_i
);

    logic              wr_en;
    logic [BW-1:0]     wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic [BW-1:0]     rd_addr;
    logic [DATA_W-1:0] rd_data;
    logic [BW:0]       committed_prod;  // writer to sender
    logic [BW:0]       committed_cons;  // sender to writer

    //////////////////////////////
    // storage
    ibuf_ram #(.BW(BW)) u_ibuf_ram (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    // writer
    mac2ibuf #(.BW(BW)) u_mac2ibuf (
        .clk              (clk),
        .rst              (rst),
        .in_i             (in_i),
        .in_valid_i       (in_valid_i),
        .in_ready_o       (in_ready_o),
        .wr_en_o          (wr_en),
        .wr_addr_o        (wr_addr),
        .wr_data_o        (wr_data),
        .committed_prod_o (committed_prod),
        .committed_cons_i (committed_cons)
    );

    // sender
    ibuf2bkd #(.BW(BW)) u_ibuf2bkd (
        .clk              (clk),
        .rst              (rst),
        .rd_addr_o        (rd_addr),
        .rd_data_i        (rd_data),
        .committed_prod_i (committed_prod),
        .committed_cons_o (committed_cons),
        .bkd_o            (bkd_o),
        .bkd_valid_o      (bkd_valid_o),
        .bkd_ready_i      (bkd_ready_i)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// testbench clock and reset source, instantiated once by the receive path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // reset released just after an edge, like the other stimulus
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1 rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: rx_ibuf_tb.sv
// self-checking testbench for the receive path that sends random packets and checks them against a byte model
`timescale 1ns/1ps
`default_nettype none

module rx_ibuf_tb
    import rx_pkt_pkg::*;
();

    localparam int N_PKTS    = 200;
    localparam int HOLD_PKT  = 100;   // output held low from this packet on
    localparam int STALL_CYC = 20;    // input blocked this long means ring full
    localparam int TIMEOUT   = 4000;  // cycles allowed in each wait loop

    logic       clk;
    logic       rst;
    rx_beat_t   in_beat;
    logic       in_valid;
    logic       in_ready;
    bkd_beat_t  bkd_beat;
    logic       bkd_valid;
    logic       bkd_ready;

    logic [31:0] in_seed;    // stimulus stream
    logic [31:0] rdy_seed;   // back-pressure stream
    logic        hold_out;   // output ready forced low
    logic        saw_stall;  // input blocked while output held
    logic [7:0]  exp_bytes [$];  // model payload bytes in order
    int          exp_len [$];    // model length of each packet
    int          cur_len;
    int          beat_idx;
    int          pkts_rx;
    logic        prev_stall;
    bkd_beat_t   prev_beat;

    tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(3)) u_tb_clk_gen (.clk_o(clk), .rst_o(rst));

    rx_ibuf_top #(.BW(5)) u_rx_ibuf_top (
        .clk         (clk),
        .rst         (rst),
        .in_i        (in_beat),
        .in_valid_i  (in_valid),
        .in_ready_o  (in_ready),
        .bkd_o       (bkd_beat),
        .bkd_valid_o (bkd_valid),
        .bkd_ready_i (bkd_ready)
    );

    //////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input logic [95:0] got, input logic [95:0] exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %0d ns: %s, got %0h expected %0h",
                                $time, what, got, exp));
        end
    endtask

    //////////////////////////////
    // input side

    task automatic send_packet(input int len);
        logic [7:0] pkt_bytes [$];
        rx_beat_t   beat;
        int         nbeats;
        int         idx;
        int         waited;
        logic       accepted;
        for (int i = 0; i < len; i++) begin
            in_seed = xorshift32(in_seed);
            pkt_bytes.push_back(in_seed[7:0]);
            exp_bytes.push_back(in_seed[7:0]);
        end
        exp_len.push_back(len);
        nbeats = (len + 7) / 8;
        for (int b = 0; b < nbeats; b++) begin
            for (int i = 0; i < 8; i++) begin
                idx = b * 8 + i;
                in_seed = xorshift32(in_seed);
                beat.data[8*i +: 8] = (idx < len) ? pkt_bytes[idx] : in_seed[15:8];  // junk lanes
            end
            beat.last   = (b == nbeats - 1);
            beat.nbytes = beat.last ? 4'(len - 8 * b) : 4'd8;
            in_seed = xorshift32(in_seed);
            if (in_seed[1:0] == 2'd0) begin  // idle gap now and then
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            in_beat  = beat;
            in_valid = 1'b1;
            accepted = 1'b0;
            waited   = 0;
            while (!accepted) begin
                @(negedge clk);  // ready stable between edges
                if (in_ready) begin
                    accepted = 1'b1;
                end else begin
                    waited++;
                    if (hold_out && waited > STALL_CYC) begin  // ring is full so let it drain
                        saw_stall = 1'b1;
                        hold_out  = 1'b0;
                    end
                    if (waited > TIMEOUT) begin
                        abort_run("input beat was not accepted before the timeout");
                    end
                end
                @(posedge clk);
                #1;
            end
        end
        in_valid = 1'b0;
    endtask

    //////////////////////////////
    // output side

    task automatic check_beat(input bkd_beat_t b);
        int         nbeats;
        int         nvalid;
        logic [7:0] exp_strb;
        logic [7:0] exp_b;
        if (beat_idx == 0) begin
            check_val(exp_len.size() > 0, 1'b1, "output beat with no packet pending");
            cur_len = exp_len.pop_front();
        end
        nbeats = (cur_len + 7) / 8;
        nvalid = (beat_idx == nbeats - 1) ? cur_len - 8 * beat_idx : 8;
        exp_strb = '0;
        for (int i = 0; i < nvalid; i++) begin
            exp_strb[i] = 1'b1;
        end
        check_val(b.user, cur_len, "user length");
        check_val(b.last, beat_idx == nbeats - 1, "last flag");
        check_val(b.strb, exp_strb, "byte strobe");
        for (int i = 0; i < nvalid; i++) begin
            check_val(exp_bytes.size() > 0, 1'b1, "more bytes out than sent");
            exp_b = exp_bytes.pop_front();
            check_val(b.data[8*i +: 8], exp_b,
                      $sformatf("data byte %0d of beat %0d, packet %0d", i, beat_idx, pkts_rx));
        end
        if (beat_idx == nbeats - 1) begin
            beat_idx = 0;
            pkts_rx++;
        end else begin
            beat_idx++;
        end
    endtask

    // random back-pressure driven just after the edge
    always begin
        @(posedge clk);
        #1;
        rdy_seed  = xorshift32(rdy_seed);
        bkd_ready = hold_out ? 1'b0 : rdy_seed[0];
    end

    // monitor samples on the falling edge where the handshake lines have settled
    always @(negedge clk) begin
        if (!rst) begin
            if (prev_stall) begin
                check_val(bkd_valid, 1'b1, "valid dropped under back-pressure");
                check_val(bkd_beat, prev_beat, "beat changed under back-pressure");
            end
            prev_stall = bkd_valid && !bkd_ready;
            prev_beat  = bkd_beat;
            if (bkd_valid && bkd_ready) check_beat(bkd_beat);
        end
    end

    //////////////////////////////
    // main sequence
    initial begin
        int n;
        int len;
        in_beat    = '0;
        in_valid   = 1'b0;
        bkd_ready  = 1'b0;
        hold_out   = 1'b0;
        saw_stall  = 1'b0;
        beat_idx   = 0;
        pkts_rx    = 0;
        cur_len    = 0;
        prev_stall = 1'b0;
        prev_beat  = '0;
        in_seed    = 32'h5f1;
        rdy_seed   = xorshift32(32'h5f1 ^ 32'h9e3779b9);  // second stream derived from the seed

        // both ready and valid low through reset
        n = 0;
        @(negedge clk);
        while (rst) begin
            check_val(in_ready, 1'b0, "input ready during reset");
            check_val(bkd_valid, 1'b0, "output valid during reset");
            @(negedge clk);
            n++;
            if (n > 50) abort_run("reset was never released");
        end
        for (int i = 0; i < 10; i++) begin  // idle with nothing sent yet
            @(negedge clk);
            check_val(bkd_valid, 1'b0, "output valid with nothing sent");
        end
        @(posedge clk);
        #1;

        for (int p = 0; p < N_PKTS; p++) begin
            if (p == HOLD_PKT) hold_out = 1'b1;  // fill the ring
            in_seed = xorshift32(in_seed);
            len = int'(in_seed % 96) + 1;
            send_packet(len);
        end

        n = 0;
        while (pkts_rx < N_PKTS) begin
            @(negedge clk);
            n++;
            if (n > TIMEOUT) abort_run("not all packets arrived before the timeout");
        end
        repeat (20) @(negedge clk);  // catch stray beats

        check_val(saw_stall, 1'b1, "input ready never dropped with output held");
        check_val(exp_bytes.size(), 0, "model bytes left over");
        check_val(exp_len.size(), 0, "model packets left over");
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: rx_ibuf.f
rx_pkt_pkg.sv
ibuf_pkg.sv
ibuf_ram.sv
mac2ibuf.sv
ibuf2bkd.sv
rx_ibuf_top.sv
tb_clk_gen.sv
rx_ibuf_tb.sv
